/* vlog.f */
+incdir+test
design/cpc_pkg.sv
design/cpc_config.sv
design/rom_loader.sv
design/rom_map_steering.sv
design/mf2_ram.sv
design/mf2_control.sv
design/cpc_expansion_top.sv
test/cpc_expansion_tb.sv

/* Makefile */
# Verilator build of the CPC expansion testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, exit status gives pass or fail"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module cpc_expansion_tb \
		-Mdir obj_dir -o cpc_expansion_sim
	./obj_dir/cpc_expansion_sim

clean:
	rm -rf obj_dir

/* test/cpc_ref_model.svh */
// Reference rules for the testbench; upper-case hex extensions only, needs cpc_pkg imported first
`ifndef CPC_REF_MODEL_SVH
`define CPC_REF_MODEL_SVH

// System ROM block to page, four images repeated for the 664 bank
function automatic page_t sys_rom_page(input int blk);
	case (blk % 4)
		0:       return '0;
		1:       return BASIC_PAGE;
		2:       return AMSDOS_PAGE;
		default: return MF2_ROM_PAGE;
	endcase
endfunction

// Minus one for anything that is not a hex digit
function automatic int hex_digit(input byte_t c);
	if (c >= "0" && c <= "9")
		return int'(c) - int'("0");
	if (c >= "A" && c <= "F")
		return int'(c) - int'("A") + 10;
	return -1;
endfunction

function automatic byte_t hex_char(input logic [3:0] v);
	if (v < 4'd10)
		return byte_t'(int'("0") + int'(v));
	return byte_t'(int'("A") + int'(v) - 10);
endfunction

function automatic page_t ext_page(input logic [15:0] ext);
	int hi;
	int lo;
	hi = hex_digit(ext[15:8]);
	lo = hex_digit(ext[7:0]);
	if (ext == "ZZ" || ext == "Z0")
		return '0;
	if (hi >= 0 && lo >= 0)
		return page_t'(256 + hi * 16 + lo);  // ROM area
	return BAD_EXT_PAGE;
endfunction

// Where an I/O write to a shadowed chip lands in Multiface RAM
function automatic mf2_addr_t shadow_addr(input byte_t port, input byte_t d,
		input logic [4:0] pen, input logic [3:0] sel);
	case (port)
		8'h7F: begin
			if (d[7:6] == 2'b00)
				return SH_PEN;
			if (d[7:6] == 2'b01)
				return pen[4] ? SH_BORDER : SH_PALETTE + mf2_addr_t'(pen[3:0]);
			if (d[7:6] == 2'b10)
				return SH_MODE;
			return SH_BANK;
		end
		8'hBC:   return SH_CRTC_SEL;
		8'hBD:   return SH_CRTC + mf2_addr_t'(sel);
		8'hF7:   return SH_PPI;
		default: return SH_ROMSEL;
	endcase
endfunction

function automatic logic rom_visible(input logic [255:0] map, input byte_t p,
		input mf2_mode_t mode);
	if (p == 8'hFF && mode == MF2_DISABLED)
		return 1'b0;  // Multiface ROM hidden when disabled
	return map[p];
endfunction

`endif

/* test/cpc_expansion_tb.sv */
// Testbench for the expansion top; fixed seed, each failure stops the run at once
`timescale 1ns/1ps

module cpc_expansion_tb;

	import cpc_pkg::*;

	localparam int N_SYS       = 24;
	localparam int N_IMG       = 6;
	localparam int N_IMG_BYTES = 4;
	localparam int N_DL        = N_SYS + N_IMG * N_IMG_BYTES;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        cfg_model;
	mf2_mode_t   cfg_mf2_mode;
	logic        cpu_reset;
	logic        dl_active;
	byte_t       dl_index;
	logic [15:0] dl_ext;
	logic        dl_wr;
	logic [24:0] dl_addr;
	byte_t       dl_data;
	logic        dl_wait;
	cpu_addr_t   cpu_addr;
	byte_t       cpu_dout;
	byte_t       cpu_din;
	addr_t       mem_addr;
	logic        mem_rd;
	logic        mem_wr;
	logic        io_wr;
	logic        m1;
	logic        key_nmi;
	logic        nmi;
	logic        mf2_active;
	logic        ce_ref;
	logic        sd_oe;
	logic        sd_we;
	addr_t       sd_addr;
	bank_t       sd_bank;
	byte_t       sd_din;
	byte_t       sd_dout;

	integer       seed = 32'hd505_2634;
	logic [31:0]  r;
	logic         exp_model;
	mf2_mode_t    exp_mode;
	logic [255:0] present = '0;    // Pages the loader has filled
	byte_t        shadow_mem [8192];
	logic [4:0]   pen_q;
	logic [3:0]   crtc_q;

	`include "cpc_ref_model.svh"

	cpc_expansion_top DUT (.*);

	always #50 clk_sys = ~clk_sys;

	// Ends a run that stalls
	initial begin
		#(100 * (64 * N_DL + 2000));
		$display("Watchdog expired before the tests finished");
		stop_run();
	end

	////////////////////
	// Helpers

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bank(input string name, input bank_t got, input bank_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic apply_reset();
		reset  = 1'b1;
		mem_rd = 1'b1;
		repeat (4) step();
		@(negedge clk_sys) check_bit("sd_oe", sd_oe, 1'b0);
		check_bit("cpu_reset", cpu_reset, 1'b1);
		step();
		mem_rd = 1'b0;
		repeat (3) step();
		reset     = 1'b0;
		exp_model = cfg_model;
		exp_mode  = cfg_mf2_mode;
		@(negedge clk_sys);
		check_bit("ce_ref", ce_ref, 1'b1);   // Divider restarts with reset
		check_bit("cpu_reset", cpu_reset, 1'b0);
		check_bit("nmi", nmi, 1'b0);
		check_bit("mf2_active", mf2_active, 1'b0);
		step();
	endtask

	// One download byte, then every memory write it causes
	task automatic send_byte(input logic [24:0] a, input byte_t d, input int n_wr,
			input addr_t ea, input bank_t eb);
		int    seen;
		bank_t cur;
		seen    = 0;
		cur     = '0;
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
		step();
		dl_wr = 1'b0;
		@(negedge clk_sys) check_bit("dl_wait", dl_wait, n_wr != 0);
		if (n_wr == 0) begin
			repeat (2 * REF_DIV) begin
				@(negedge clk_sys) check_bit("sd_we", sd_we, 1'b0);
			end
		end else begin
			while (dl_wait) begin
				if (sd_we) begin
					if (seen == 0 || sd_bank != cur) begin
						cur = sd_bank;
						check_bank("sd_bank", sd_bank, (n_wr == 2) ? bank_t'(seen) : eb);
						seen++;
					end
					check_addr("sd_addr", sd_addr, ea);
					check_byte("sd_din", sd_din, d);
				end
				@(negedge clk_sys);
			end
			if (seen != n_wr) begin
				$display("Download byte caused %0d bank writes instead of %0d", seen, n_wr);
				stop_run();
			end
			if (ea[22])
				present[ea[21:14]] = 1'b1;
		end
		step();
	endtask

	task automatic port_write(input cpu_addr_t a, input byte_t d);
		cpu_addr = a;
		cpu_dout = d;
		io_wr    = 1'b1;
		step();
		io_wr = 1'b0;
	endtask

	task automatic shadow_check(input byte_t port, input byte_t d);
		mf2_addr_t sa;
		r  = $random(seed);
		sa = shadow_addr(port, d, pen_q, crtc_q);
		port_write({port, r[7:0]}, d);
		shadow_mem[sa] = d;
		if (port == 8'h7F && d[7:6] == 2'b00)
			pen_q = d[4:0];
		if (port == 8'hBC)
			crtc_q = d[3:0];
		step();
		cpu_addr = {3'b001, sa};   // Window at 0x2000
		mem_addr = {10'b0, sa};
		mem_rd   = 1'b1;
		sd_dout  = r[15:8];
		repeat (2) step();
		@(negedge clk_sys) check_byte("cpu_din", cpu_din, shadow_mem[sa] & sd_dout);
		step();
		mem_rd = 1'b0;
	endtask

	////////////////////
	// Tests

	initial begin
		int        blk;
		page_t     pg;
		byte_t     idx;
		byte_t     p;
		mf2_mode_t mode;
		logic [13:0] off;
		logic [15:0] ext;
		byte_t     ports [5];
		ports = '{8'h7F, 8'hBC, 8'hBD, 8'hF7, 8'hDF};
		reset = 1'b1;
		cfg_model = 1'b0;
		cfg_mf2_mode = MF2_ENABLED;
		dl_active = 1'b0;
		dl_index = '0;
		dl_ext = '0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cpu_addr = '0;
		cpu_dout = '0;
		mem_addr = '0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		io_wr = 1'b0;
		m1 = 1'b0;
		key_nmi = 1'b0;
		sd_dout = 8'hFF;

		// Model latched at reset, later menu changes ignored
		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			cfg_model = r[0];
			apply_reset();
			step();
			cfg_model = r[1];
			key_nmi   = 1'b1;    // Left pending for the next reset to clear
			mem_rd    = 1'b1;
			mem_addr  = {1'b0, r[23:2]};
			step();
			@(negedge clk_sys) check_bank("sd_bank", sd_bank, {1'b0, exp_model});
			check_bit("nmi", nmi, 1'b1);
			step();
			key_nmi = 1'b0;
			mem_rd  = 1'b0;
		end
		cfg_model = exp_model;

		// System ROM download
		dl_index  = '0;
		dl_active = 1'b1;
		step();
		@(negedge clk_sys) check_bit("cpu_reset", cpu_reset, 1'b1);  // Loader owns memory
		step();
		for (int i = 0; i < N_SYS; i++) begin
			r   = $random(seed);
			blk = int'(r[3:0]) % 9;
			off = r[17:4];
			send_byte({11'(blk), off}, r[25:18], (blk < 8) ? 1 : 0,
				{sys_rom_page(blk), off}, {1'b0, blk >= 4});
		end
		dl_active = 1'b0;
		repeat (2) step();

		// Expansion ROM images
		for (int i = 0; i < N_IMG; i++) begin
			r = $random(seed);
			if (i == N_IMG - 2)
				ext = "ZZ";
			else if (i == N_IMG - 1)
				ext = "Q7";            // Malformed
			else
				ext = {hex_char(r[3:0]), hex_char(r[7:4])};
			idx       = (i == 1) ? 8'hC1 : 8'h01;   // 0xC1 goes to bank 1 only
			pg        = ext_page(ext);
			dl_index  = idx;
			dl_ext    = ext;
			dl_active = 1'b1;
			repeat (2) step();
			for (int j = 0; j < N_IMG_BYTES; j++) begin
				r   = $random(seed);
				off = r[13:0];
				send_byte({11'b0, off}, r[21:14], (&idx[7:6]) ? 1 : 2, {pg, off}, 2'b01);
			end
			dl_active = 1'b0;
			repeat (2) step();
		end

		// Presence of upper ROM pages
		for (int i = 0; i < 40; i++) begin
			r        = $random(seed);
			p        = (i < 8) ? byte_t'(present[r[7:0]] ? r[7:0] : 8'h07) : r[7:0];
			mem_addr = {1'b1, p, r[21:8]};
			mem_rd   = 1'b1;
			step();
			@(negedge clk_sys) check_bit("sd_oe", sd_oe, rom_visible(present, p, exp_mode));
			step();
		end
		mem_rd = 1'b0;

		// NMI entry in each mode, enabled last
		for (int k = 0; k < 3; k++) begin
			mode         = (k == 0) ? MF2_DISABLED : (k == 1) ? MF2_HIDDEN : MF2_ENABLED;
			cfg_mf2_mode = mode;
			apply_reset();
			key_nmi = 1'b1;
			step();
			@(negedge clk_sys) check_bit("nmi", nmi, mode != MF2_DISABLED);
			step();
			key_nmi = 1'b0;
			if (mode != MF2_DISABLED) begin
				cpu_addr = NMI_VECTOR;
				m1       = 1'b1;
				step();
				@(negedge clk_sys) check_bit("mf2_active", mf2_active, 1'b1);
				check_bit("nmi", nmi, 1'b0);
				step();
				m1       = 1'b0;
				r        = $random(seed);
				cpu_addr = {3'b000, r[12:0]};
				mem_addr = {1'b0, r[31:10]};
				mem_rd   = 1'b1;
				@(negedge clk_sys) check_addr("sd_addr", sd_addr, {MF2_ROM_PAGE, 1'b0, r[12:0]});
				step();
				mem_rd = 1'b0;
			end
		end

		// Shadow writes, pen and CRTC select known first
		r = $random(seed);
		shadow_check(8'h7F, {3'b000, r[4:0]});
		shadow_check(8'hBC, r[15:8]);
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			shadow_check(ports[int'(r[10:8]) % 5], r[7:0]);
		end

		// Multiface port, then hide
		port_write(16'hFEEA, 8'h00);
		@(negedge clk_sys) check_bit("mf2_active", mf2_active, 1'b0);
		step();
		port_write(MF2_PORT, 8'h00);
		@(negedge clk_sys) check_bit("mf2_active", mf2_active, 1'b1);
		step();
		cpu_addr = MF2_HIDE_ADDR;
		m1       = 1'b1;
		step();
		m1 = 1'b0;
		step();
		port_write(MF2_PORT, 8'h00);
		@(negedge clk_sys) check_bit("mf2_active", mf2_active, 1'b0);  // Hidden stays off

		$display("Simulation passed");
		$finish;
	end

endmodule

/* design/cpc_expansion_top.sv */
// Memory-side expansion of a CPC 6128; the SDRAM controller sits outside and samples on ce_ref
`timescale 1ns/1ps

module cpc_expansion_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                cfg_model,
	input  cpc_pkg::mf2_mode_t  cfg_mf2_mode,
	output logic                cpu_reset,
	// Download port
	input  logic                dl_active,
	input  cpc_pkg::byte_t      dl_index,
	input  logic [15:0]         dl_ext,
	input  logic                dl_wr,
	input  logic [24:0]         dl_addr,
	input  cpc_pkg::byte_t      dl_data,
	output logic                dl_wait,
	// CPU side
	input  cpc_pkg::cpu_addr_t  cpu_addr,
	input  cpc_pkg::byte_t      cpu_dout,
	output cpc_pkg::byte_t      cpu_din,
	input  cpc_pkg::addr_t      mem_addr,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  logic                io_wr,
	input  logic                m1,
	input  logic                key_nmi,
	output logic                nmi,
	output logic                mf2_active,
	// Memory side
	output logic                ce_ref,
	output logic                sd_oe,
	output logic                sd_we,
	output cpc_pkg::addr_t      sd_addr,
	output cpc_pkg::bank_t      sd_bank,
	output cpc_pkg::byte_t      sd_din,
	input  cpc_pkg::byte_t      sd_dout
);

	import cpc_pkg::*;

	logic      model;
	mf2_mode_t mf2_mode;
	logic      rom_dl;
	logic      boot_we;
	addr_t     boot_addr;
	bank_t     boot_bank;
	byte_t     boot_data;
	logic      map_set;
	byte_t     map_page;
	byte_t     mf2_data;

	assign cpu_reset = reset | rom_dl; // CPU held while ROMs load

	cpc_config u_config (
		.clk_sys (clk_sys), .reset (cpu_reset),
		.cfg_model (cfg_model), .cfg_mf2_mode (cfg_mf2_mode),
		.model (model), .mf2_mode (mf2_mode)
	);

	rom_loader u_loader (
		.clk_sys (clk_sys), .reset (reset),
		.dl_active (dl_active), .dl_index (dl_index), .dl_ext (dl_ext),
		.dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
		.dl_wait (dl_wait), .rom_dl (rom_dl), .ce_ref (ce_ref),
		.boot_we (boot_we), .boot_addr (boot_addr), .boot_bank (boot_bank),
		.boot_data (boot_data), .map_set (map_set), .map_page (map_page)
	);

	rom_map_steering u_steer (
		.clk_sys (clk_sys), .cpu_reset (cpu_reset), .model (model), .mf2_mode (mf2_mode),
		.boot_we (boot_we), .boot_addr (boot_addr), .boot_bank (boot_bank),
		.boot_data (boot_data), .map_set (map_set), .map_page (map_page),
		.mem_addr (mem_addr), .mem_rd (mem_rd), .mem_wr (mem_wr),
		.cpu_addr (cpu_addr), .cpu_dout (cpu_dout),
		.mf2_active (mf2_active), .mf2_data (mf2_data), .sd_dout (sd_dout),
		.sd_oe (sd_oe), .sd_we (sd_we), .sd_addr (sd_addr), .sd_bank (sd_bank),
		.sd_din (sd_din), .cpu_din (cpu_din)
	);

	mf2_control u_mf2 (
		.clk_sys (clk_sys), .reset (cpu_reset), .mf2_mode (mf2_mode),
		.cpu_addr (cpu_addr), .cpu_dout (cpu_dout), .mem_addr (mem_addr),
		.mem_rd (mem_rd), .mem_wr (mem_wr), .io_wr (io_wr), .m1 (m1),
		.key_nmi (key_nmi), .nmi (nmi), .mf2_active (mf2_active),
		.mf2_data (mf2_data)
	);

endmodule

/* design/mf2_control.sv */
// Multiface Two logic; writes to port 0xFEE8 or 0xFEEA outrank shadowing, which outranks CPU writes
`timescale 1ns/1ps

module mf2_control (
	input  logic                clk_sys,
	input  logic                reset,
	input  cpc_pkg::mf2_mode_t  mf2_mode,
	input  cpc_pkg::cpu_addr_t  cpu_addr,
	input  cpc_pkg::byte_t      cpu_dout,
	input  cpc_pkg::addr_t      mem_addr,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  logic                io_wr,
	input  logic                m1,
	input  logic                key_nmi,
	output logic                nmi,
	output logic                mf2_active,
	output cpc_pkg::byte_t      mf2_data
);

	import cpc_pkg::*;

	logic      old_key_nmi;
	logic      old_m1;
	logic      old_io_wr;
	logic      hidden;
	logic [4:0] pen_index;
	logic [3:0] crtc_sel;
	logic      ram_we;
	mf2_addr_t ram_addr;
	byte_t     ram_wdata;
	byte_t     ram_rdata;
	mf2_addr_t store_addr;
	logic      ram_en;
	logic      io_edge;
	logic      m1_edge;
	logic      port_hit;
	logic      shadow_hit;
	logic      cpu_ram_wr;

	assign ram_en     = mf2_active && (cpu_addr[15:13] == 3'b001); // 0x2000 to 0x3FFF
	assign io_edge    = !old_io_wr && io_wr;
	assign m1_edge    = !old_m1 && m1;
	assign port_hit   = io_edge && (cpu_addr[15:2] == MF2_PORT[15:2]);
	assign shadow_hit = io_edge && !port_hit && (store_addr != '0);
	assign cpu_ram_wr = !port_hit && !shadow_hit && mem_wr && ram_en;

	////////////////////
	// Shadow store decode

	always_comb begin
		case (cpu_addr[15:8])
			8'h7F: begin  // Gate array, function in the top data bits
				case (cpu_dout[7:6])
					2'b00:   store_addr = SH_PEN;
					2'b01:   store_addr = pen_index[4] ? SH_BORDER
						: {SH_PALETTE[12:4], pen_index[3:0]};
					2'b10:   store_addr = SH_MODE;
					default: store_addr = SH_BANK;
				endcase
			end
			8'hBC:   store_addr = SH_CRTC_SEL;
			8'hBD:   store_addr = {SH_CRTC[12:4], crtc_sel};
			8'hF7:   store_addr = SH_PPI;
			8'hDF:   store_addr = SH_ROMSEL;
			default: store_addr = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_key_nmi <= 1'b0;
			old_m1      <= 1'b0;
			old_io_wr   <= 1'b0;
			nmi         <= 1'b0;
			mf2_active  <= 1'b0;
			hidden      <= (mf2_mode != MF2_ENABLED);
			ram_we      <= 1'b0;
		end else begin
			old_key_nmi <= key_nmi;
			old_m1      <= m1;
			old_io_wr   <= io_wr;

			if (!old_key_nmi && key_nmi && !mf2_active && (mf2_mode != MF2_DISABLED))
				nmi <= 1'b1;
			if (nmi && m1_edge && (cpu_addr == NMI_VECTOR)) begin
				mf2_active <= 1'b1;   // Entry fetch pages in ROM and RAM
				hidden     <= 1'b0;
				nmi        <= 1'b0;
			end
			if (mf2_active && m1_edge && (cpu_addr == MF2_HIDE_ADDR))
				hidden <= 1'b1;
			if (port_hit)
				mf2_active <= !cpu_addr[1] && !hidden;

			ram_we <= shadow_hit || cpu_ram_wr;
		end
	end

	// RAM address follows the CPU unless a write is pending
	always_ff @(posedge clk_sys) begin
		if (shadow_hit) begin
			if (cpu_addr[15:8] == 8'h7F && cpu_dout[7:6] == 2'b00)
				pen_index <= cpu_dout[4:0];
			if (cpu_addr[15:8] == 8'hBC)
				crtc_sel <= cpu_dout[3:0];
			ram_addr  <= store_addr;
			ram_wdata <= cpu_dout;
		end else if (!port_hit) begin
			ram_addr  <= mem_addr[12:0];
			ram_wdata <= cpu_dout;
		end
	end

	mf2_ram u_ram (
		.clk_sys (clk_sys),
		.we      (ram_we),
		.addr    (ram_addr),
		.wdata   (ram_wdata),
		.rdata   (ram_rdata)
	);

	assign mf2_data = (ram_en && mem_rd) ? ram_rdata : 8'hFF;

endmodule

/* design/mf2_ram.sv */
// Single-port 8 KB RAM with no reset; a write shows its data on rdata in the next cycle
`timescale 1ns/1ps

module mf2_ram (
	input  logic                clk_sys,
	input  logic                we,
	input  cpc_pkg::mf2_addr_t  addr,
	input  cpc_pkg::byte_t      wdata,
	output cpc_pkg::byte_t      rdata
);

	localparam int DEPTH = 1 << $bits(addr);

	logic [7:0] mem [DEPTH];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata     <= wdata; // Write-through
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

/* design/rom_map_steering.sv */
// Presence table powers up empty and survives resets; the loader owns memory while cpu_reset is high
`timescale 1ns/1ps

module rom_map_steering (
	input  logic                clk_sys,
	input  logic                cpu_reset,
	input  logic                model,
	input  cpc_pkg::mf2_mode_t  mf2_mode,
	input  logic                boot_we,
	input  cpc_pkg::addr_t      boot_addr,
	input  cpc_pkg::bank_t      boot_bank,
	input  cpc_pkg::byte_t      boot_data,
	input  logic                map_set,
	input  cpc_pkg::byte_t      map_page,
	input  cpc_pkg::addr_t      mem_addr,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  cpc_pkg::cpu_addr_t  cpu_addr,
	input  cpc_pkg::byte_t      cpu_dout,
	input  logic                mf2_active,
	input  cpc_pkg::byte_t      mf2_data,
	input  cpc_pkg::byte_t      sd_dout,
	output logic                sd_oe,
	output logic                sd_we,
	output cpc_pkg::addr_t      sd_addr,
	output cpc_pkg::bank_t      sd_bank,
	output cpc_pkg::byte_t      sd_din,
	output cpc_pkg::byte_t      cpu_din
);

	import cpc_pkg::*;

	logic [255:0] rom_map = '0;  // One bit per upper-ROM page
	byte_t        map_addr;
	logic         rom_mask;
	logic         mf2_ram_en;
	logic         mf2_rom_en;

	always_ff @(posedge clk_sys) begin
		if (map_set)
			rom_map[map_page] <= 1'b1;
		map_addr <= mem_addr[21:14];
	end

	// Empty slot, or the Multiface ROM page with the Multiface disabled
	assign rom_mask = mem_addr[22] &
		(!rom_map[map_addr] | ((&map_addr) & (mf2_mode == MF2_DISABLED)));

	assign mf2_ram_en = mf2_active && (cpu_addr[15:13] == 3'b001);
	assign mf2_rom_en = mf2_active && (cpu_addr[15:13] == 3'b000);

	////////////////////
	// Request mux

	always_comb begin
		if (cpu_reset) begin
			sd_oe   = 1'b0;
			sd_we   = boot_we;
			sd_addr = boot_addr;
			sd_bank = boot_bank;
			sd_din  = boot_data;
		end else begin
			sd_oe   = mem_rd & ~mf2_ram_en & ~rom_mask;
			sd_we   = mem_wr & ~mf2_ram_en & ~mf2_rom_en; // Multiface ROM is read only
			sd_addr = mf2_rom_en ? {MF2_ROM_PAGE, cpu_addr[13:0]} : mem_addr;
			sd_bank = {1'b0, model};
			sd_din  = cpu_dout;
		end
	end

	assign cpu_din = sd_dout & mf2_data; // Idle sources drive all ones

endmodule

/* design/rom_loader.sv */
// ROM downloads only; the host must hold dl_wr while dl_wait is high, and a byte takes 17 to 48 clocks
`timescale 1ns/1ps

module rom_loader (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             dl_active,
	input  cpc_pkg::byte_t   dl_index,
	input  logic [15:0]      dl_ext,
	input  logic             dl_wr,
	input  logic [24:0]      dl_addr,
	input  cpc_pkg::byte_t   dl_data,
	output logic             dl_wait,
	output logic             rom_dl,
	output logic             ce_ref,
	output logic             boot_we,
	output cpc_pkg::addr_t   boot_addr,
	output cpc_pkg::bank_t   boot_bank,
	output cpc_pkg::byte_t   boot_data,
	output logic             map_set,
	output cpc_pkg::byte_t   map_page
);

	import cpc_pkg::*;

	localparam int DIV_W = $clog2(REF_DIV);

	logic [DIV_W-1:0] div;
	logic             old_active;
	logic             combo;        // Z0 image, OS first then BASIC
	page_t            page;         // Start page of the current expansion image
	logic [10:0]      sys_block;
	logic             sys_valid;
	page_t            sys_page;
	logic [4:0]       ext_hi;
	logic [4:0]       ext_lo;
	logic             accept;
	logic             dl_start;
	logic             strobe_end;
	logic             both_banks;
	logic             bank_step;
	logic             write_done;

	// Valid flag on top of the nibble value
	function automatic logic [4:0] hex_nibble(input byte_t ch);
		logic [4:0] r;
		r = 5'b0;
		if (ch >= "0" && ch <= "9")
			r = {1'b1, ch[3:0]};
		else if (ch >= "A" && ch <= "F")
			r = {1'b1, ch[3:0] + 4'd9};
		return r;
	endfunction

	// Low five index bits give the file type, top two are flags
	assign rom_dl = dl_active && (dl_index[4:0] < ROM_INDEX_LIMIT);
	assign ce_ref = (div == '0);

	assign accept   = rom_dl && dl_wr;
	assign dl_start = !old_active && dl_active && (dl_index != '0);
	assign ext_hi   = hex_nibble(dl_ext[15:8]);
	assign ext_lo   = hex_nibble(dl_ext[7:0]);

	////////////////////
	// System ROM blocks

	assign sys_block = dl_addr[24:14];
	assign sys_valid = (sys_block < 11'd8);

	always_comb begin
		case (sys_block[1:0])
			2'd0:    sys_page = '0;           // OS
			2'd1:    sys_page = BASIC_PAGE;
			2'd2:    sys_page = AMSDOS_PAGE;
			default: sys_page = MF2_ROM_PAGE;
		endcase
	end

	////////////////////
	// Strobe sequencing

	assign strobe_end = ce_ref && boot_we && dl_wait;
	// Expansion images go to both banks unless the index flags bank 1 only
	assign both_banks = (dl_index != '0) && !boot_bank[0];
	assign bank_step  = strobe_end && both_banks;
	assign write_done = strobe_end && !both_banks;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div        <= '0;
			old_active <= 1'b0;
			dl_wait    <= 1'b0;
			boot_we    <= 1'b0;
			map_set    <= 1'b0;
			combo      <= 1'b0;
			page       <= BAD_EXT_PAGE;
		end else begin
			div        <= (div == DIV_W'(REF_DIV - 1)) ? '0 : div + 1'b1;
			old_active <= dl_active;
			map_set    <= write_done && boot_addr[22]; // Only the ROM area is mapped

			if (accept)
				dl_wait <= (dl_index != '0) || sys_valid; // Blocks above 7 are dropped

			if (ce_ref)
				boot_we <= dl_wait;  // Bank step keeps we high into bank 1

			if (write_done) begin
				boot_we <= 1'b0;
				dl_wait <= 1'b0;
				if (combo && (&boot_addr[13:0])) begin
					combo <= 1'b0;
					page  <= MF2_ROM_PAGE;
				end
			end

			if (dl_start) begin
				combo <= (dl_ext == "Z0");
				if (dl_ext == "ZZ" || dl_ext == "Z0")
					page <= '0;
				else if (ext_hi[4] && ext_lo[4])
					page <= {1'b1, ext_hi[3:0], ext_lo[3:0]}; // 0x100 plus hex value
				else
					page <= BAD_EXT_PAGE;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			boot_data       <= dl_data;
			boot_addr[13:0] <= dl_addr[13:0];
			if (dl_index != '0) begin
				boot_addr[22:14] <= {page[8], page[7:0] + dl_addr[21:14]};
				boot_bank        <= {1'b0, &dl_index[7:6]};
			end else begin
				boot_addr[22:14] <= sys_page;
				boot_bank        <= {1'b0, sys_block[2]}; // Blocks 4 to 7 for the 664
			end
		end
		if (bank_step)
			boot_bank <= 2'b01;
		if (write_done)
			map_page <= boot_addr[21:14];
	end

endmodule

/* design/cpc_config.sv */
// Model and Multiface mode follow the menu only while reset is high and hold in between
`timescale 1ns/1ps

module cpc_config (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                cfg_model,
	input  cpc_pkg::mf2_mode_t  cfg_mf2_mode,
	output logic                model,
	output cpc_pkg::mf2_mode_t  mf2_mode
);

	logic               model_q;
	cpc_pkg::mf2_mode_t mode_q;

	// A menu change takes effect at the next reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= cfg_model;
			mode_q  <= cfg_mf2_mode;
		end
	end

	assign model    = model_q;  // 0 is the 6128, 1 the 664
	assign mf2_mode = mode_q;

endmodule

/* design/cpc_pkg.sv */
// Shared widths and fixed addresses. The ROM area is addr_t bit 22 and Multiface RAM is 8 KB
package cpc_pkg;

	typedef logic [22:0] addr_t;     // External memory word address
	typedef logic [1:0]  bank_t;     // Bit 0 picks the 664 bank
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [12:0] mf2_addr_t;
	typedef logic [8:0]  page_t;     // Top 9 bits of addr_t

	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_t;

	////////////////////
	// ROM pages

	localparam page_t MF2_ROM_PAGE = 9'h1FF;
	localparam page_t BASIC_PAGE   = 9'h100;
	localparam page_t AMSDOS_PAGE  = 9'h107;
	localparam page_t BAD_EXT_PAGE = 9'h1EE; // Unused page for malformed extensions

	////////////////////
	// CPU side addresses

	localparam cpu_addr_t NMI_VECTOR    = 16'h0066;
	localparam cpu_addr_t MF2_HIDE_ADDR = 16'h0065;
	localparam cpu_addr_t MF2_PORT      = 16'hFEE8; // Bit 1 set turns the Multiface off

	////////////////////
	// Shadow store slots in Multiface RAM

	localparam mf2_addr_t SH_PEN      = 13'h1FCF;
	localparam mf2_addr_t SH_BORDER   = 13'h1FDF;
	localparam mf2_addr_t SH_PALETTE  = 13'h1F90; // Plus pen index
	localparam mf2_addr_t SH_MODE     = 13'h1FEF;
	localparam mf2_addr_t SH_BANK     = 13'h1FFF;
	localparam mf2_addr_t SH_CRTC_SEL = 13'h1CFF;
	localparam mf2_addr_t SH_CRTC     = 13'h1DB0; // Plus CRTC register number
	localparam mf2_addr_t SH_PPI      = 13'h17FF;
	localparam mf2_addr_t SH_ROMSEL   = 13'h1AAC;

	localparam int REF_DIV         = 16; // Clocks per reference strobe
	localparam int ROM_INDEX_LIMIT = 4;  // Lower download indexes carry ROMs

endpackage
